/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // data and instruction word
    localparam int word_w = 16;
    typedef logic [word_w-1:0] word_t;

    // instruction field widths
    localparam int op_w       = 4;
    localparam int func_w     = 4;
    localparam int addr_w_max = 12;
    // operand address field of an alu instruction
    localparam int alu_addr_w = 8;

    // major opcode in bits 15:12
    // codes not listed run as nop
    typedef enum logic [op_w-1:0] {
        op_nop = 4'd0,
        op_lda = 4'd1,
        op_sta = 4'd2,
        op_alu = 4'd3,
        op_jmp = 4'd4,
        op_jz  = 4'd5,
        op_out = 4'd6,
        op_ldi = 4'd7,
        op_hlt = 4'd15
    } major_op_t;

    // alu function in bits 11:8
    typedef enum logic [func_w-1:0] {
        fn_add,
        fn_sub,
        fn_mul,
        fn_div,
        fn_shl,
        fn_shr,
        fn_rol,
        fn_ror,
        fn_and,
        fn_or,
        fn_xor,
        fn_nor,
        fn_nand,
        fn_xnor,
        fn_gt,
        fn_eq
    } alu_func_t;

    // accumulator input select
    typedef logic [1:0] acc_src_t;
    localparam acc_src_t acc_src_mem = 2'd0;
    localparam acc_src_t acc_src_alu = 2'd1;
    localparam acc_src_t acc_src_imm = 2'd2;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_operand_wait,
        st_execute,
        st_halted
    } cpu_state_t;

endpackage

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_func_t func,
    input  cpu_pkg::word_t     operand1,
    input  cpu_pkg::word_t     operand2,
    output cpu_pkg::word_t     result
);
    import cpu_pkg::*;

    // operand1 is always the accumulator
    always_comb begin
        case (func)
            fn_add: result = operand1 + operand2;
            fn_sub: result = operand1 - operand2;
            // low half of the product only
            fn_mul: result = operand1 * operand2;
            // divide by zero saturates to all ones
            fn_div: begin
                if (operand2 == '0) begin
                    result = '1;
                end else begin
                    result = operand1 / operand2;
                end
            end
            // single bit shifts, operand2 ignored
            fn_shl: result = operand1 << 1;
            fn_shr: result = operand1 >> 1;
            fn_rol: result = {operand1[word_w-2:0], operand1[word_w-1]};
            fn_ror: result = {operand1[0], operand1[word_w-1:1]};
            // bitwise group
            fn_and:  result = operand1 & operand2;
            fn_or:   result = operand1 | operand2;
            fn_xor:  result = operand1 ^ operand2;
            fn_nor:  result = ~(operand1 | operand2);
            fn_nand: result = ~(operand1 & operand2);
            fn_xnor: result = ~(operand1 ^ operand2);
            // compares give 1 or 0, unsigned
            fn_gt: begin
                if (operand1 > operand2) begin
                    result = word_t'(1);
                end else begin
                    result = '0;
                end
            end
            fn_eq: begin
                if (operand1 == operand2) begin
                    result = word_t'(1);
                end else begin
                    result = '0;
                end
            end
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* main_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module main_memory #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    input  cpu_pkg::word_t    wdata,
    input  logic              we,
    output cpu_pkg::word_t    rdata,
    input  logic              load_en,
    input  logic [ADDR_W-1:0] load_addr,
    input  cpu_pkg::word_t    load_data
);
    import cpu_pkg::*;

    localparam int depth = 2 ** ADDR_W;

    word_t mem [depth];

    // load port wins over the cpu port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (we) begin
            mem[addr] <= wdata;
        end
        // registered read every cycle, old data on a same-address write
        rdata <= mem[addr];
    end

    // loading only happens while the cpu is idle or halted
    a_no_load_during_write: assert property (@(posedge clk)
        !(we === 1'b1 && load_en === 1'b1));

endmodule

`default_nettype wire

/* program_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module program_counter #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  logic              inc,
    input  logic              jump,
    input  logic [ADDR_W-1:0] jump_addr,
    output logic [ADDR_W-1:0] pc
);

    // reset first, then clear, jump and increment
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (clear) begin
            // start of a new run
            pc <= '0;
        end else if (jump) begin
            pc <= jump_addr;
        end else if (inc) begin
            // wrap at the top of memory
            if (pc == '1) begin
                pc <= '0;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    // inc comes in fetch_wait, jump in decode
    a_inc_jump_excl: assert property (@(posedge clk) disable iff (rst)
        !(inc && jump));

endmodule

`default_nettype wire

/* datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath #(
    parameter int ADDR_W = 12
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ir_load,
    input  logic                           acc_load,
    input  cpu_pkg::acc_src_t              acc_src,
    input  logic                           addr_sel,
    input  logic [ADDR_W-1:0]              pc,
    input  cpu_pkg::word_t                 mem_rdata,
    output cpu_pkg::major_op_t             major_op,
    output cpu_pkg::alu_func_t             alu_func,
    output logic [cpu_pkg::addr_w_max-1:0] addr_field,
    output cpu_pkg::word_t                 acc,
    output logic                           acc_zero,
    output logic [ADDR_W-1:0]              mem_addr
);
    import cpu_pkg::*;

    word_t             ir;
    word_t             alu_result;
    word_t             imm;
    logic [ADDR_W-1:0] operand_addr;

    // address width must cover the alu operand field and fit the instruction
    if (ADDR_W < alu_addr_w || ADDR_W > addr_w_max) begin : g_addr_w_check
        $error("datapath: ADDR_W out of range 8 to 12");
    end

    // instruction fields
    assign major_op   = major_op_t'(ir[word_w-1 -: op_w]);
    assign alu_func   = alu_func_t'(ir[addr_w_max-1 -: func_w]);
    assign addr_field = ir[addr_w_max-1:0];
    // ldi immediate, zero extended
    assign imm = word_t'(addr_field);

    // alu instructions only carry an 8-bit operand address
    always_comb begin
        if (major_op == op_alu) begin
            operand_addr = ADDR_W'(ir[alu_addr_w-1:0]);
        end else begin
            operand_addr = ir[ADDR_W-1:0];
        end
    end

    // pc during fetch, operand address from decode on
    assign mem_addr = addr_sel ? operand_addr : pc;

    alu alu_i (
        .func     (alu_func),
        .operand1 (acc),
        .operand2 (mem_rdata),
        .result   (alu_result)
    );

    // ir resets to a nop
    always_ff @(posedge clk) begin
        if (rst) begin
            ir  <= '0;
            acc <= '0;
        end else begin
            if (ir_load) begin
                ir <= mem_rdata;
            end
            if (acc_load) begin
                case (acc_src)
                    acc_src_mem: acc <= mem_rdata;
                    acc_src_alu: acc <= alu_result;
                    acc_src_imm: acc <= imm;
                    default:     acc <= acc;
                endcase
            end
        end
    end

    // jz condition
    assign acc_zero = (acc == '0);

    // an alu result is only taken after a fetched instruction set the function
    a_alu_func_known: assert property (@(posedge clk) disable iff (rst)
        (acc_load && acc_src == acc_src_alu) |-> !$isunknown(alu_func));

endmodule

`default_nettype wire

/* control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  cpu_pkg::major_op_t major_op,
    input  logic               acc_zero,
    output logic               ir_load,
    output logic               acc_load,
    output cpu_pkg::acc_src_t  acc_src,
    output logic               addr_sel,
    output logic               mem_we,
    output logic               pc_inc,
    output logic               pc_jump,
    output logic               pc_clear,
    output logic               out_valid,
    output logic               halted
);
    import cpu_pkg::*;

    cpu_state_t state;
    cpu_state_t state_next;
    logic       in_decode;
    logic       needs_operand;
    logic       ready;

    assign in_decode = (state == st_decode);
    // lda and alu read a second word
    assign needs_operand = (major_op == op_lda) || (major_op == op_alu);
    // start only honoured when nothing runs
    assign ready = (state == st_idle) || (state == st_halted);

    always_comb begin
        state_next = state;
        case (state)
            st_idle, st_halted: begin
                if (start) begin
                    state_next = st_fetch;
                end
            end
            // instruction address on the bus
            st_fetch: state_next = st_fetch_wait;
            // instruction word valid on rdata
            st_fetch_wait: state_next = st_decode;
            st_decode: begin
                if (needs_operand) begin
                    state_next = st_operand_wait;
                end else if (major_op == op_hlt) begin
                    state_next = st_halted;
                end else begin
                    state_next = st_fetch;
                end
            end
            // operand address held, data lands on rdata
            st_operand_wait: state_next = st_execute;
            st_execute: state_next = st_fetch;
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // pc cleared together with the move to fetch
    assign pc_clear = start && ready;

    // capture instruction and step pc in the same cycle
    assign ir_load = (state == st_fetch_wait);
    assign pc_inc  = (state == st_fetch_wait);

    // operand address stays on the bus until execute
    assign addr_sel = in_decode || (state == st_operand_wait) || (state == st_execute);

    // single cycle actions in decode
    assign mem_we    = in_decode && (major_op == op_sta);
    assign out_valid = in_decode && (major_op == op_out);
    assign pc_jump   = in_decode &&
                       ((major_op == op_jmp) || ((major_op == op_jz) && acc_zero));

    // ldi writes acc from decode, lda and alu from execute
    assign acc_load = (in_decode && (major_op == op_ldi)) || (state == st_execute);

    always_comb begin
        case (major_op)
            op_lda:  acc_src = acc_src_mem;
            op_alu:  acc_src = acc_src_alu;
            default: acc_src = acc_src_imm;
        endcase
    end

    assign halted = (state == st_halted);

    // out strobe is a single cycle pulse
    a_out_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid);

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_en,
    input  logic [ADDR_W-1:0] load_addr,
    input  cpu_pkg::word_t    load_data,
    input  logic              start,
    output logic              halted,
    output logic              out_valid,
    output cpu_pkg::word_t    out_data,
    output cpu_pkg::word_t    acc
);
    import cpu_pkg::*;

    // control strobes
    logic     ir_load;
    logic     acc_load;
    acc_src_t acc_src;
    logic     addr_sel;
    logic     mem_we;
    logic     pc_inc;
    logic     pc_jump;
    logic     pc_clear;

    // decode status back to control
    major_op_t             major_op;
    logic                  acc_zero;
    logic [addr_w_max-1:0] addr_field;

    // address and data buses
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] mem_addr;
    word_t             mem_rdata;

    control_unit control_unit_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .major_op  (major_op),
        .acc_zero  (acc_zero),
        .ir_load   (ir_load),
        .acc_load  (acc_load),
        .acc_src   (acc_src),
        .addr_sel  (addr_sel),
        .mem_we    (mem_we),
        .pc_inc    (pc_inc),
        .pc_jump   (pc_jump),
        .pc_clear  (pc_clear),
        .out_valid (out_valid),
        .halted    (halted)
    );

    // alu function only feeds the alu inside the datapath
    datapath #(
        .ADDR_W (ADDR_W)
    ) datapath_i (
        .clk        (clk),
        .rst        (rst),
        .ir_load    (ir_load),
        .acc_load   (acc_load),
        .acc_src    (acc_src),
        .addr_sel   (addr_sel),
        .pc         (pc),
        .mem_rdata  (mem_rdata),
        .major_op   (major_op),
        .alu_func   (),
        .addr_field (addr_field),
        .acc        (acc),
        .acc_zero   (acc_zero),
        .mem_addr   (mem_addr)
    );

    // jump target is the low part of the address field
    program_counter #(
        .ADDR_W (ADDR_W)
    ) program_counter_i (
        .clk       (clk),
        .rst       (rst),
        .clear     (pc_clear),
        .inc       (pc_inc),
        .jump      (pc_jump),
        .jump_addr (addr_field[ADDR_W-1:0]),
        .pc        (pc)
    );

    // sta stores the accumulator
    main_memory #(
        .ADDR_W (ADDR_W)
    ) main_memory_i (
        .clk       (clk),
        .addr      (mem_addr),
        .wdata     (acc),
        .we        (mem_we),
        .rdata     (mem_rdata),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    assign out_data = acc;

endmodule

`default_nettype wire

/* cpu_model.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// major opcodes of the isa
localparam logic [3:0] op_nop = 4'h0;
localparam logic [3:0] op_lda = 4'h1;
localparam logic [3:0] op_sta = 4'h2;
localparam logic [3:0] op_alu = 4'h3;
localparam logic [3:0] op_jmp = 4'h4;
localparam logic [3:0] op_jz  = 4'h5;
localparam logic [3:0] op_out = 4'h6;
localparam logic [3:0] op_ldi = 4'h7;
localparam logic [3:0] op_hlt = 4'hf;

// program at 0..63, data words at 128..255
localparam int prog_len   = 64;
localparam int data_base  = 128;
localparam int data_words = 128;

logic [15:0] prog_mem [0:4095];
logic [15:0] model_mem [0:4095];
logic [15:0] exp_out [$];
// acc survives start, only reset clears it
logic [15:0] model_acc = 16'h0000;
integer      gen_slot;
// alu functions handed out in turn so every one gets used
logic [3:0]  alu_next = 4'h0;

function automatic logic [15:0] alu_ref(input logic [3:0] f, input logic [15:0] a,
                                        input logic [15:0] b);
    logic [31:0] full;
    begin
        full = a * b;
        case (f)
            4'd0:  alu_ref = a + b;
            4'd1:  alu_ref = a - b;
            // product truncated to the low word
            4'd2:  alu_ref = full[15:0];
            4'd3:  alu_ref = (b == 16'h0000) ? 16'hffff : a / b;
            4'd4:  alu_ref = {a[14:0], 1'b0};
            4'd5:  alu_ref = {1'b0, a[15:1]};
            4'd6:  alu_ref = (a << 1) | (a >> 15);
            4'd7:  alu_ref = (a >> 1) | (a << 15);
            4'd8:  alu_ref = a & b;
            4'd9:  alu_ref = a | b;
            4'd10: alu_ref = a ^ b;
            4'd11: alu_ref = ~(a | b);
            4'd12: alu_ref = ~(a & b);
            4'd13: alu_ref = ~(a ^ b);
            4'd14: alu_ref = (a > b) ? 16'h0001 : 16'h0000;
            default: alu_ref = (a == b) ? 16'h0001 : 16'h0000;
        endcase
    end
endfunction

// random immediate that is zero one time in four so jz gets taken
function automatic logic [11:0] rand_imm();
    integer r;
    begin
        r = $random(seed);
        if (r[1:0] == 2'b00) begin
            rand_imm = 12'h000;
        end else begin
            rand_imm = r[13:2];
        end
    end
endfunction

// slot 63 is kept for hlt
task automatic put_word(input logic [15:0] w);
    begin
        if (gen_slot < prog_len - 1) begin
            prog_mem[gen_slot] = w;
            gen_slot = gen_slot + 1;
        end
    end
endtask

task automatic gen_program();
    integer a;
    integer r;
    integer kind;
    integer dat;
    integer tgt;
    logic [3:0] f;
    begin
        gen_slot = 0;
        while (gen_slot < prog_len - 1) begin
            kind = {$random(seed)} % 8;
            dat = data_base + {$random(seed)} % data_words;
            case (kind)
                0: begin
                    put_word({op_ldi, rand_imm()});
                    put_word({op_out, 12'h000});
                end
                1: begin
                    put_word({op_lda, dat[11:0]});
                    put_word({op_out, 12'h000});
                end
                2: begin
                    f = alu_next;
                    alu_next = alu_next + 4'h1;
                    // word 128 stays zero for the divide by zero case
                    if (f == 4'd3 && $random(seed) % 2 == 0) begin
                        dat = data_base;
                    end
                    put_word({op_alu, f, dat[7:0]});
                    put_word({op_out, 12'h000});
                end
                3: begin
                    // word 128 is never a store target
                    if (dat == data_base) begin
                        dat = data_base + 1;
                    end
                    // store, overwrite acc, read the word back
                    put_word({op_sta, dat[11:0]});
                    put_word({op_ldi, rand_imm()});
                    put_word({op_lda, dat[11:0]});
                    put_word({op_out, 12'h000});
                end
                4, 5: begin
                    // forward jump over up to three words
                    tgt = gen_slot + 1 + {$random(seed)} % 4;
                    if (tgt > prog_len - 1) begin
                        tgt = prog_len - 1;
                    end
                    put_word({(kind == 4) ? op_jmp : op_jz, tgt[11:0]});
                end
                6: begin
                    // nop or one of the unused codes 8..14
                    a = {$random(seed)} % 8;
                    r = $random(seed);
                    put_word({(a == 0) ? op_nop : 4'(7 + a), r[11:0]});
                end
                default: put_word({op_out, 12'h000});
            endcase
        end
        prog_mem[prog_len - 1] = {op_hlt, 12'h000};
        for (a = data_base; a < data_base + data_words; a++) begin
            r = $random(seed);
            prog_mem[a] = (r[2:0] == 3'd0) ? 16'h0000 : r[31:16];
        end
        prog_mem[data_base] = 16'h0000;
    end
endtask

// interpreter that fills exp_out and moves model_acc
task automatic run_model();
    integer a;
    integer pc;
    integer steps;
    logic [15:0] ins;
    logic done;
    begin
        for (a = 0; a < data_base + data_words; a++) begin
            model_mem[a] = prog_mem[a];
        end
        exp_out.delete();
        pc = 0;
        steps = 0;
        done = 1'b0;
        while (!done) begin
            ins = model_mem[pc];
            pc = (pc + 1) % 4096;
            case (ins[15:12])
                op_lda: model_acc = model_mem[ins[11:0]];
                op_sta: model_mem[ins[11:0]] = model_acc;
                op_alu: model_acc = alu_ref(ins[11:8], model_acc, model_mem[ins[7:0]]);
                op_jmp: pc = ins[11:0];
                op_jz: begin
                    if (model_acc == 16'h0000) begin
                        pc = ins[11:0];
                    end
                end
                op_out: exp_out.push_back(model_acc);
                op_ldi: model_acc = {4'h0, ins[11:0]};
                op_hlt: done = 1'b1;
                default: ;
            endcase
            steps = steps + 1;
            check_true(steps <= 4096, "model ran past the step limit without reaching HLT");
        end
    end
endtask

`endif

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam int num_progs   = 8;
    // worst case run of 64 five-cycle instructions plus the load
    localparam int prog_cycles = 64 * 5 + 192 + 40;
    localparam int timeout_ns  = (num_progs * prog_cycles + 3 * 16 + 100) * 8;

    logic        clk;
    logic        rst;
    logic        load_en;
    logic [11:0] load_addr;
    logic [15:0] load_data;
    logic        start;
    logic        halted;
    logic        out_valid;
    logic [15:0] out_data;
    logic [15:0] acc;
    integer      seed = 4;
    integer      prog_idx;

    `include "cpu_model.svh"

    cpu_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start),
        .halted    (halted),
        .out_valid (out_valid),
        .out_data  (out_data),
        .acc       (acc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog
    initial begin
        #(timeout_ns);
        $display("ERROR: run did not finish within %0d ns", timeout_ns);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    task automatic check_word(input string name, input logic [15:0] exp_val,
                              input logic [15:0] act_val);
        begin
            assert (act_val === exp_val) else begin
                $display("FAILED %s: expected %h, actual %h", name, exp_val, act_val);
                $display("TEST FAIL");
                $fatal(1, "value mismatch");
            end
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        begin
            assert (cond === 1'b1) else begin
                $display("ERROR: %s", msg);
                $display("TEST FAIL");
                $fatal(1, "check failed");
            end
        end
    endtask

    // hold reset for 16 cycles and check the outputs at rest
    task automatic apply_reset();
        begin
            @(negedge clk);
            rst = 1'b1;
            repeat (16) @(negedge clk);
            rst = 1'b0;
            model_acc = 16'h0000;
            check_word("reset halted", 16'h0000, halted);
            check_word("reset out_valid", 16'h0000, out_valid);
            check_word("reset acc", 16'h0000, acc);
        end
    endtask

    // write program words and the data region one word per cycle
    task automatic load_program();
        integer a;
        begin
            for (a = 0; a < data_base + data_words; a++) begin
                if (a < prog_len || a >= data_base) begin
                    @(negedge clk);
                    load_en = 1'b1;
                    load_addr = a[11:0];
                    load_data = prog_mem[a];
                end
            end
            @(negedge clk);
            load_en = 1'b0;
        end
    endtask

    task automatic run_program(input integer p);
        integer k;
        logic [15:0] exp_word;
        begin
            gen_program();
            run_model();
            load_program();
            @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            k = 0;
            // one sample per cycle between rising edges
            while (halted !== 1'b1) begin
                if (out_valid === 1'b1) begin
                    check_true(exp_out.size() > 0, "out_valid strobe with no OUT left in model");
                    exp_word = exp_out.pop_front();
                    check_word($sformatf("prog%0d out%0d", p, k), exp_word, out_data);
                    k = k + 1;
                end
                @(negedge clk);
            end
            check_true(exp_out.size() == 0, "processor halted before all OUT strobes came");
            check_word($sformatf("prog%0d final acc", p), model_acc, acc);
            // halted holds while no start comes
            repeat (2) @(negedge clk);
            check_word($sformatf("prog%0d halted hold", p), 16'h0001, halted);
            check_word($sformatf("prog%0d out_valid idle", p), 16'h0000, out_valid);
        end
    endtask

    initial begin
        rst = 1'b1;
        load_en = 1'b0;
        load_addr = 12'h000;
        load_data = 16'h0000;
        start = 1'b0;
        apply_reset();
        // later programs reload and restart from halted
        for (prog_idx = 0; prog_idx < num_progs; prog_idx++) begin
            run_program(prog_idx);
            if (prog_idx == num_progs / 2 - 1) begin
                apply_reset();
            end
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
cpu_pkg.sv
alu.sv
main_memory.sv
program_counter.sv
datapath.sv
control_unit.sv
cpu_top.sv
tb_cpu.sv
